// ==== src.f ====
hw/axi_rd_pkg.sv
hw/mm2s_pkg.sv
hw/mm2s_cmd_decode.sv
hw/mm2s_burst_ctrl.sv
hw/mm2s_burst_tag_fifo.sv
hw/mm2s_rdata_tagger.sv
hw/mm2s_stream_fifo.sv
hw/mm2s_top.sv
tb/axi_rd_slave_model.sv
tb/tb_mm2s.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mm2s \
	-f src.f -Mdir obj_dir -o sim_mm2s
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_mm2s > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
exit 0

// ==== tb/tb_mm2s.sv ====
module tb_mm2s;

	localparam int NUM_CMDS = 40;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * 400;
	localparam logic [31:0] SEED = 32'd10;

	logic m_axi_aclk;
	logic m_axi_aresetn;
	mm2s_pkg::mm2s_cmd_t cmd_i;
	logic cmd_valid_i;
	logic cmd_ready;
	axi_rd_pkg::axi_ar_t ar;
	logic [3:0] arcache;
	logic [2:0] arprot;
	logic arvalid;
	logic arready;
	axi_rd_pkg::axi_r_t r;
	logic rvalid;
	logic rready;
	mm2s_pkg::stream_beat_t m_beat;
	logic m_valid;
	logic m_ready_i;
	logic [31:0] slave_rand;

	mm2s_pkg::stream_beat_t exp_q [$];   // model of the output stream
	axi_rd_pkg::axi_addr_t ar_next_q [$]; // next burst address per command
	int ar_left_q [$];                    // beats still to request per command
	int errors = 0;
	int cycles = 0;
	int beats_out = 0;
	int beats_total = 0;
	logic [31:0] cmd_rng = SEED;
	logic [31:0] stall_rng = SEED ^ 32'h5555_5555; // separate stream for stalls
	mm2s_pkg::mm2s_cmd_t cmd;
	logic [19:0] page;
	logic [11:0] offset;

	mm2s_top i_dut (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_ready_o   (cmd_ready),
		.ar_o          (ar),
		.arcache_o     (arcache),
		.arprot_o      (arprot),
		.arvalid_o     (arvalid),
		.arready_i     (arready),
		.r_i           (r),
		.rvalid_i      (rvalid),
		.rready_o      (rready),
		.m_beat_o      (m_beat),
		.m_valid_o     (m_valid),
		.m_ready_i     (m_ready_i)
	);

	axi_rd_slave_model i_slave (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.ar_i          (ar),
		.arvalid_i     (arvalid),
		.arready_o     (arready),
		.r_o           (r),
		.rvalid_o      (rvalid),
		.rready_i      (rready),
		.rand_i        (slave_rand)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// memory contents and error window as the slave defines them
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return addr ^ 32'hA5A5_0000;
	endfunction

	function automatic logic [1:0] expected_resp(input logic [31:0] addr);
		return (addr >= 32'h0030_0000 && addr <= 32'h0030_0FFF) ? 2'b10 : 2'b00;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic queue_expected(input mm2s_pkg::mm2s_cmd_t c);
		int start_off;
		int end_off;
		int beats;
		logic [31:0] word_addr;
		mm2s_pkg::keep_t first_keep;
		mm2s_pkg::keep_t last_keep;
		mm2s_pkg::stream_beat_t b;
		start_off = int'(c.addr[1:0]);
		end_off = int'(c.btt) + start_off;
		beats = (end_off + mm2s_pkg::DATA_BYTES - 1) / mm2s_pkg::DATA_BYTES;
		for (int i = 0; i < mm2s_pkg::DATA_BYTES; i++)
		begin
			first_keep[i] = i >= start_off;
			last_keep[i] = (end_off % mm2s_pkg::DATA_BYTES == 0)
				|| (i < end_off % mm2s_pkg::DATA_BYTES);
		end
		word_addr = {c.addr[31:2], 2'b00};
		ar_next_q.push_back(word_addr);
		ar_left_q.push_back(beats);
		beats_total += beats;
		for (int n = 0; n < beats; n++)
		begin
			b.data = expected_word(word_addr);
			b.keep = '1;
			if (n == 0)
				b.keep = b.keep & first_keep;
			if (n == beats - 1)
				b.keep = b.keep & last_keep; // single beat gets both masks
			b.user = {n == beats - 1, expected_resp(word_addr)};
			b.last = (n == beats - 1) && c.eof;
			exp_q.push_back(b);
			word_addr += mm2s_pkg::DATA_BYTES;
		end
	endtask

	task automatic check_ar(input axi_rd_pkg::axi_ar_t a);
		int burst_beats;
		burst_beats = int'(a.len) + 1;
		check_value("ar.size", a.size, 3'd2);   // 4 bytes per beat
		check_value("ar.burst", a.burst, 2'b01); // INCR
		check_value("arcache", arcache, axi_rd_pkg::AXI_CACHE_DEFAULT);
		check_value("arprot", arprot, axi_rd_pkg::AXI_PROT_DEFAULT);
		if (burst_beats > mm2s_pkg::MAX_BURST_LEN)
		begin
			errors++;
			$display("at %0t: AR burst of %0d beats is longer than allowed", $time, burst_beats);
		end
		if (int'(a.addr[11:0]) + burst_beats * mm2s_pkg::DATA_BYTES > mm2s_pkg::PAGE_BYTES)
		begin
			errors++;
			$display("at %0t: AR burst at %h crosses a 4 KB page", $time, a.addr);
		end
		if (ar_next_q.size() == 0)
		begin
			errors++;
			$display("at %0t: AR burst issued with no command pending", $time);
		end
		else
		begin
			check_value("ar.addr", a.addr, ar_next_q[0]);
			ar_next_q[0] = ar_next_q[0] + burst_beats * mm2s_pkg::DATA_BYTES;
			ar_left_q[0] = ar_left_q[0] - burst_beats;
			if (ar_left_q[0] <= 0)
			begin
				check_value("beats left after last burst", ar_left_q[0], 0);
				ar_next_q.pop_front();
				ar_left_q.pop_front();
			end
		end
	endtask

	task automatic check_beat(input mm2s_pkg::stream_beat_t got);
		mm2s_pkg::stream_beat_t exp;
		beats_out++;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("at %0t: output beat arrived with none expected", $time);
		end
		else
		begin
			exp = exp_q.pop_front();
			check_value("m_beat.data", got.data, exp.data);
			check_value("m_beat.keep", got.keep, exp.keep);
			check_value("m_beat.user", got.user, exp.user);
			check_value("m_beat.last", got.last, exp.last);
		end
	endtask

	initial
	begin
		m_axi_aclk = 1'b0;
		forever #4 m_axi_aclk = ~m_axi_aclk;
	end

	// sample both handshakes at the edge
	always @(posedge m_axi_aclk)
	begin
		if (m_axi_aresetn && arvalid && arready)
			check_ar(ar);
		if (m_axi_aresetn && m_valid && m_ready_i)
			check_beat(m_beat);
	end

	always @(posedge m_axi_aclk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d, output beats: %0d of %0d", errors, beats_out, beats_total);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial
	begin
		m_ready_i = 1'b0;
		slave_rand = '0;
		forever
		begin
			@(posedge m_axi_aclk);
			#1;
			stall_rng = xorshift32(stall_rng);
			m_ready_i = stall_rng[4];
			slave_rand = stall_rng;
		end
	end

	initial
	begin
		m_axi_aresetn = 1'b0;
		cmd_i = '0;
		cmd_valid_i = 1'b0;
		repeat (5) @(posedge m_axi_aclk);
		#1;
		// idle handshake levels out of reset
		check_value("cmd_ready", cmd_ready, 1'b1);
		check_value("arvalid", arvalid, 1'b0);
		check_value("rready", rready, 1'b0);
		check_value("m_valid", m_valid, 1'b0);
		m_axi_aresetn = 1'b1;
		for (int n = 0; n < NUM_CMDS; n++)
		begin
			cmd_rng = xorshift32(cmd_rng);
			page = 20'h002FF + 20'(cmd_rng[9:8]); // pages around the error window
			if (cmd_rng[10])
				offset = 12'hFFF - 12'(cmd_rng[16:11]); // just below a boundary
			else
				offset = cmd_rng[23:12];
			cmd.addr = {page, offset};
			cmd.eof = cmd_rng[24];
			cmd_rng = xorshift32(cmd_rng);
			cmd.btt = mm2s_pkg::btt_t'(1 + cmd_rng % 300);
			cmd_i = cmd;
			cmd_valid_i = 1'b1;
			@(posedge m_axi_aclk);
			while (!cmd_ready)
				@(posedge m_axi_aclk);
			queue_expected(cmd);
			#1;
		end
		cmd_valid_i = 1'b0;
		while (exp_q.size() != 0 || ar_next_q.size() != 0)
			@(posedge m_axi_aclk);
		repeat (50) @(posedge m_axi_aclk); // catch extra beats
		check_value("output beat count", beats_out, beats_total);
		$display("errors: %0d, output beats: %0d of %0d", errors, beats_out, beats_total);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== tb/axi_rd_slave_model.sv ====
module axi_rd_slave_model (
	input  logic m_axi_aclk,
	input  logic m_axi_aresetn,
	input  axi_rd_pkg::axi_ar_t ar_i,
	input  logic arvalid_i,
	output logic arready_o,
	output axi_rd_pkg::axi_r_t r_o,
	output logic rvalid_o,
	input  logic rready_i,
	input  logic [31:0] rand_i   // new random word each cycle
);

	localparam axi_rd_pkg::axi_addr_t ERR_LO = 32'h0030_0000;
	localparam axi_rd_pkg::axi_addr_t ERR_HI = 32'h0030_0FFF;

	axi_rd_pkg::axi_addr_t addr_q [$];   // accepted AR requests
	int len_q [$];
	int beat;
	logic [31:0] rnd;
	logic r_hold;
	axi_rd_pkg::axi_addr_t beat_addr;

	initial
	begin
		arready_o = 1'b0;
		rvalid_o = 1'b0;
		r_o = '0;
		beat = 0;
		forever
		begin
			@(posedge m_axi_aclk);
			rnd = rand_i;
			r_hold = rvalid_o && !rready_i; // beat offered but not taken
			if (arvalid_i && arready_o)
			begin
				addr_q.push_back(ar_i.addr);
				len_q.push_back(int'(ar_i.len));
			end
			if (rvalid_o && rready_i)
			begin
				if (beat == len_q[0])
				begin
					addr_q.pop_front();
					len_q.pop_front();
					beat = 0;
				end
				else
					beat++;
			end
			#1;
			if (!m_axi_aresetn)
			begin
				arready_o = 1'b0;
				rvalid_o = 1'b0;
			end
			else
			begin
				arready_o = rnd[1:0] != 2'b00; // stalls about one cycle in four
				if (!r_hold)
					rvalid_o = (addr_q.size() != 0) && (rnd[3:2] != 2'b00);
				if (rvalid_o)
				begin
					beat_addr = addr_q[0] + axi_rd_pkg::axi_addr_t'(beat * mm2s_pkg::DATA_BYTES);
					r_o.data = beat_addr ^ 32'hA5A5_0000;
					r_o.resp = (beat_addr >= ERR_LO && beat_addr <= ERR_HI)
						? axi_rd_pkg::AXI_RESP_SLVERR : axi_rd_pkg::AXI_RESP_OKAY;
					r_o.last = beat == len_q[0];
				end
			end
		end
	end

endmodule

// ==== hw/mm2s_top.sv ====
module mm2s_top (
	input  logic m_axi_aclk,
	input  logic m_axi_aresetn,
	input  mm2s_pkg::mm2s_cmd_t cmd_i,
	input  logic cmd_valid_i,
	output logic cmd_ready_o,
	output axi_rd_pkg::axi_ar_t ar_o,
	output logic [3:0] arcache_o,
	output logic [2:0] arprot_o,
	output logic arvalid_o,
	input  logic arready_i,
	input  axi_rd_pkg::axi_r_t r_i,
	input  logic rvalid_i,
	output logic rready_o,
	output mm2s_pkg::stream_beat_t m_beat_o,
	output logic m_valid_o,
	input  logic m_ready_i
);

	mm2s_pkg::beat_cnt_t beat_cnt;
	mm2s_pkg::keep_t first_keep;
	mm2s_pkg::keep_t last_keep;
	mm2s_pkg::burst_tag_t tag_new;
	mm2s_pkg::burst_tag_t tag_head;
	logic tag_push;
	logic tag_pop;
	logic tag_full;
	logic tag_empty;
	mm2s_pkg::stream_beat_t tagged_beat;
	logic beat_push;
	logic stream_full;

	assign arcache_o = axi_rd_pkg::AXI_CACHE_DEFAULT;
	assign arprot_o = axi_rd_pkg::AXI_PROT_DEFAULT;
	assign tag_push = arvalid_o & arready_i; // tag enters on AR handshake

	mm2s_cmd_decode i_decode (
		.cmd_i        (cmd_i),
		.beat_cnt_o   (beat_cnt),
		.first_keep_o (first_keep),
		.last_keep_o  (last_keep)
	);

	mm2s_burst_ctrl i_ctrl (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.cmd_i         (cmd_i),
		.cmd_valid_i   (cmd_valid_i),
		.cmd_ready_o   (cmd_ready_o),
		.beat_cnt_i    (beat_cnt),
		.first_keep_i  (first_keep),
		.last_keep_i   (last_keep),
		.tag_full_i    (tag_full),
		.tag_o         (tag_new),
		.ar_o          (ar_o),
		.arvalid_o     (arvalid_o),
		.arready_i     (arready_i)
	);

	mm2s_burst_tag_fifo #(
		.DEPTH (mm2s_pkg::BURST_SLOTS)
	) i_tag_fifo (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.push_i        (tag_push),
		.tag_i         (tag_new),
		.full_o        (tag_full),
		.pop_i         (tag_pop),
		.tag_o         (tag_head),
		.empty_o       (tag_empty)
	);

	mm2s_rdata_tagger i_tagger (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.r_i           (r_i),
		.rvalid_i      (rvalid_i),
		.rready_o      (rready_o),
		.tag_i         (tag_head),
		.tag_empty_i   (tag_empty),
		.tag_pop_o     (tag_pop),
		.beat_o        (tagged_beat),
		.push_o        (beat_push),
		.stream_full_i (stream_full)
	);

	mm2s_stream_fifo #(
		.DEPTH (mm2s_pkg::STREAM_DEPTH)
	) i_stream_fifo (
		.m_axi_aclk    (m_axi_aclk),
		.m_axi_aresetn (m_axi_aresetn),
		.push_i        (beat_push),
		.beat_i        (tagged_beat),
		.full_o        (stream_full),
		.beat_o        (m_beat_o),
		.valid_o       (m_valid_o),
		.ready_i       (m_ready_i)
	);

endmodule

// ==== hw/mm2s_stream_fifo.sv ====
module mm2s_stream_fifo #(
	parameter int DEPTH = mm2s_pkg::STREAM_DEPTH // power of two
) (
	input  logic m_axi_aclk,
	input  logic m_axi_aresetn,
	input  logic push_i,
	input  mm2s_pkg::stream_beat_t beat_i,
	output logic full_o,
	output mm2s_pkg::stream_beat_t beat_o,
	output logic valid_o,
	input  logic ready_i
);

	mm2s_pkg::stream_beat_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;   // words in mem, output reg not counted
	logic out_free;
	logic mem_empty;
	logic mem_wr;
	logic mem_rd;

	assign full_o = count[$clog2(DEPTH)];
	assign mem_empty = count == '0;
	assign out_free = ~valid_o | ready_i;
	assign mem_rd = out_free & ~mem_empty;
	assign mem_wr = push_i & ~(out_free & mem_empty); // else straight to output reg

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			valid_o <= 1'b0;
		end
		else
		begin
			if (mem_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (mem_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (mem_wr && !mem_rd)
				count <= count + 1'b1;
			else if (mem_rd && !mem_wr)
				count <= count - 1'b1;
			if (out_free)
				valid_o <= ~mem_empty | push_i;
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (mem_wr)
			mem[wr_ptr] <= beat_i;
		if (mem_rd)
			beat_o <= mem[rd_ptr];
		else if (out_free && push_i)
			beat_o <= beat_i; // bypass when empty
	end

	assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		push_i |-> !full_o)
		else $error("stream FIFO written while full");

endmodule

// ==== hw/mm2s_rdata_tagger.sv ====
module mm2s_rdata_tagger (
	input  logic m_axi_aclk,
	input  logic m_axi_aresetn,
	input  axi_rd_pkg::axi_r_t r_i,
	input  logic rvalid_i,
	output logic rready_o,
	input  mm2s_pkg::burst_tag_t tag_i,
	input  logic tag_empty_i,
	output logic tag_pop_o,
	output mm2s_pkg::stream_beat_t beat_o,
	output logic push_o,
	input  logic stream_full_i
);

	logic first_trans;   // next beat opens a command
	logic last_trans;
	mm2s_pkg::keep_t head_keep;
	mm2s_pkg::keep_t tail_keep;

	// R only moves with a tag for its burst and room downstream
	assign rready_o = ~tag_empty_i & ~stream_full_i;
	assign push_o = rvalid_i & rready_o;
	assign tag_pop_o = push_o & r_i.last;

	// rlast of the last burst closes the command
	assign last_trans = r_i.last & tag_i.last_burst;

	assign head_keep = first_trans ? tag_i.first_keep : '1;
	assign tail_keep = last_trans ? tag_i.last_keep : '1;

	assign beat_o.data = r_i.data;
	assign beat_o.keep = head_keep & tail_keep; // one-beat command gets both masks
	assign beat_o.user = {last_trans, r_i.resp};
	assign beat_o.last = last_trans & tag_i.eof;

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			first_trans <= 1'b1;
		else if (push_o)
			first_trans <= last_trans;
	end

endmodule

// ==== hw/mm2s_burst_tag_fifo.sv ====
module mm2s_burst_tag_fifo #(
	parameter int DEPTH = mm2s_pkg::BURST_SLOTS // power of two
) (
	input  logic m_axi_aclk,
	input  logic m_axi_aresetn,
	input  logic push_i,
	input  mm2s_pkg::burst_tag_t tag_i,
	output logic full_o,
	input  logic pop_i,
	output mm2s_pkg::burst_tag_t tag_o,
	output logic empty_o
);

	mm2s_pkg::burst_tag_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;

	assign full_o = count[$clog2(DEPTH)]; // count == DEPTH
	assign empty_o = count == '0;
	assign tag_o = mem[rd_ptr]; // head shows without a read

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_i && !pop_i)
				count <= count + 1'b1;
			else if (pop_i && !push_i)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (push_i)
			mem[wr_ptr] <= tag_i;
	end

	assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		(push_i |-> !full_o) and (pop_i |-> !empty_o))
		else $error("burst tag FIFO overflow or underflow");

endmodule

// ==== hw/mm2s_burst_ctrl.sv ====
module mm2s_burst_ctrl (
	input  logic m_axi_aclk,
	input  logic m_axi_aresetn,
	input  mm2s_pkg::mm2s_cmd_t cmd_i,
	input  logic cmd_valid_i,
	output logic cmd_ready_o,
	input  mm2s_pkg::beat_cnt_t beat_cnt_i,
	input  mm2s_pkg::keep_t first_keep_i,
	input  mm2s_pkg::keep_t last_keep_i,
	input  logic tag_full_i,
	output mm2s_pkg::burst_tag_t tag_o,
	output axi_rd_pkg::axi_ar_t ar_o,
	output logic arvalid_o,
	input  logic arready_i
);

	mm2s_pkg::ctrl_state_e state_q;
	mm2s_pkg::beat_cnt_t rmn_beats_m1;   // beats left in command - 1
	mm2s_pkg::page_beat_t page_rmn_m1;   // beats left in current page - 1
	axi_rd_pkg::axi_addr_t araddr_q;
	axi_rd_pkg::axi_len_t min_res;       // ends up as arlen
	logic a_leq_b_pre;
	logic last_burst_q;
	mm2s_pkg::keep_t first_keep_q;
	mm2s_pkg::keep_t last_keep_q;
	logic eof_q;
	logic arvalid_q;
	logic cmd_fire;
	logic ar_fire;
	logic cmp_en;
	mm2s_pkg::beat_cnt_t op_a;
	mm2s_pkg::page_beat_t op_b;
	logic a_leq_b;
	mm2s_pkg::beat_cnt_t burst_beats;

	assign cmd_ready_o = state_q == mm2s_pkg::IDLE;
	assign cmd_fire = cmd_valid_i & cmd_ready_o;
	assign ar_fire = arvalid_q & arready_i;
	assign burst_beats = mm2s_pkg::beat_cnt_t'(min_res) + 1'b1;

	// one comparator, two passes
	// PLAN_MAX: remaining vs max burst, PLAN_PAGE: previous result vs page remainder
	assign op_a = (state_q == mm2s_pkg::PLAN_MAX) ? rmn_beats_m1
		: mm2s_pkg::beat_cnt_t'(min_res);
	assign op_b = (state_q == mm2s_pkg::PLAN_MAX)
		? mm2s_pkg::page_beat_t'(mm2s_pkg::MAX_BURST_LEN - 1) : page_rmn_m1;
	assign a_leq_b = op_a <= mm2s_pkg::beat_cnt_t'(op_b);
	assign cmp_en = ((state_q == mm2s_pkg::PLAN_MAX) & ~tag_full_i)
		| (state_q == mm2s_pkg::PLAN_PAGE);

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			state_q <= mm2s_pkg::IDLE;
		else
		begin
			case (state_q)
				mm2s_pkg::IDLE:
					if (cmd_valid_i)
						state_q <= mm2s_pkg::PLAN_MAX;
				mm2s_pkg::PLAN_MAX:
					if (!tag_full_i) // wait for a free tag slot
						state_q <= mm2s_pkg::PLAN_PAGE;
				mm2s_pkg::PLAN_PAGE:
					state_q <= mm2s_pkg::LAUNCH;
				default:
					if (arready_i)
						state_q <= last_burst_q ? mm2s_pkg::IDLE : mm2s_pkg::PLAN_MAX;
			endcase
		end
	end

	always_ff @(posedge m_axi_aclk or negedge m_axi_aresetn)
	begin
		if (!m_axi_aresetn)
			arvalid_q <= 1'b0;
		else if (state_q == mm2s_pkg::PLAN_PAGE)
			arvalid_q <= 1'b1;
		else if (ar_fire)
			arvalid_q <= 1'b0;
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (cmd_fire)
		begin
			rmn_beats_m1 <= beat_cnt_i - 1'b1;
			page_rmn_m1 <= ~cmd_i.addr[mm2s_pkg::PAGE_ADDR_W-1:mm2s_pkg::BYTE_IDX_W];
			araddr_q <= cmd_i.addr & ~axi_rd_pkg::axi_addr_t'(mm2s_pkg::DATA_BYTES - 1);
			first_keep_q <= first_keep_i;
			last_keep_q <= last_keep_i;
			eof_q <= cmd_i.eof;
		end
		else if (ar_fire && !last_burst_q)
		begin
			rmn_beats_m1 <= rmn_beats_m1 - burst_beats;
			page_rmn_m1 <= page_rmn_m1 - mm2s_pkg::page_beat_t'(burst_beats); // wraps at page end
			araddr_q <= araddr_q + (axi_rd_pkg::axi_addr_t'(burst_beats) << mm2s_pkg::BYTE_IDX_W);
		end
	end

	always_ff @(posedge m_axi_aclk)
	begin
		if (cmp_en)
		begin
			min_res <= a_leq_b ? axi_rd_pkg::axi_len_t'(op_a) : axi_rd_pkg::axi_len_t'(op_b);
			a_leq_b_pre <= a_leq_b;
		end
		if (state_q == mm2s_pkg::PLAN_PAGE)
			last_burst_q <= a_leq_b_pre & a_leq_b; // remaining count won both passes
	end

	assign ar_o.addr = araddr_q;
	assign ar_o.len = min_res;
	assign ar_o.size = axi_rd_pkg::axi_size_t'(mm2s_pkg::BYTE_IDX_W);
	assign ar_o.burst = axi_rd_pkg::AXI_BURST_INCR;
	assign arvalid_o = arvalid_q;

	assign tag_o.last_burst = last_burst_q;
	assign tag_o.first_keep = first_keep_q;
	assign tag_o.last_keep = last_keep_q;
	assign tag_o.eof = eof_q;

	// burst end must stay inside the 4 KB page of its start
	assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		ar_fire |-> int'(ar_o.addr[mm2s_pkg::PAGE_ADDR_W-1:0])
			+ (int'(ar_o.len) + 1) * mm2s_pkg::DATA_BYTES <= mm2s_pkg::PAGE_BYTES)
		else $error("AR burst crosses a 4 KB page");

	assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
		arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
		else $error("AR request dropped or changed before arready");

endmodule

// ==== hw/mm2s_cmd_decode.sv ====
module mm2s_cmd_decode (
	input  mm2s_pkg::mm2s_cmd_t cmd_i,
	output mm2s_pkg::beat_cnt_t beat_cnt_o,
	output mm2s_pkg::keep_t first_keep_o,
	output mm2s_pkg::keep_t last_keep_o
);

	logic [mm2s_pkg::BYTE_IDX_W-1:0] start_off;
	logic [$bits(mm2s_pkg::btt_t):0] end_addr;   // one spare bit for the carry
	logic [mm2s_pkg::BYTE_IDX_W-1:0] end_off;

	assign start_off = cmd_i.addr[mm2s_pkg::BYTE_IDX_W-1:0];
	assign end_addr = {1'b0, cmd_i.btt} + $bits(end_addr)'(start_off);
	assign end_off = end_addr[mm2s_pkg::BYTE_IDX_W-1:0];

	// round up to whole bus words
	assign beat_cnt_o = mm2s_pkg::beat_cnt_t'(end_addr[$bits(end_addr)-1:mm2s_pkg::BYTE_IDX_W])
		+ mm2s_pkg::beat_cnt_t'(|end_off);

	always_comb
	begin
		for (int i = 0; i < mm2s_pkg::DATA_BYTES; i++)
		begin
			first_keep_o[i] = start_off <= i[mm2s_pkg::BYTE_IDX_W-1:0];
			// aligned end keeps the whole word
			last_keep_o[i] = (end_off > i[mm2s_pkg::BYTE_IDX_W-1:0]) || (end_off == '0);
		end
	end

endmodule

// ==== hw/mm2s_pkg.sv ====
package mm2s_pkg;

	localparam int DATA_W = axi_rd_pkg::AXI_DATA_W;
	localparam int DATA_BYTES = DATA_W / 8;
	localparam int BYTE_IDX_W = $clog2(DATA_BYTES);
	localparam int MAX_BURST_LEN = 16;
	localparam int PAGE_BYTES = 4096;
	localparam int PAGE_ADDR_W = $clog2(PAGE_BYTES);
	localparam int BURST_SLOTS = 4;   // also the outstanding burst limit
	localparam int STREAM_DEPTH = 64;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [DATA_BYTES-1:0] keep_t;
	typedef logic [23:0] btt_t;
	typedef logic [23:0] beat_cnt_t;
	typedef logic [PAGE_ADDR_W-BYTE_IDX_W-1:0] page_beat_t;

	typedef struct packed {
		btt_t btt;
		axi_rd_pkg::axi_addr_t addr;
		logic eof;
	} mm2s_cmd_t;

	// one entry per launched burst
	typedef struct packed {
		logic last_burst;
		keep_t first_keep;
		keep_t last_keep;
		logic eof;
	} burst_tag_t;

	// user is {last transfer of command, rresp}
	typedef struct packed {
		data_t data;
		keep_t keep;
		logic [2:0] user;
		logic last;
	} stream_beat_t;

	typedef enum logic [1:0] {
		IDLE,
		PLAN_MAX,
		PLAN_PAGE,
		LAUNCH
	} ctrl_state_e;

endpackage

// ==== hw/axi_rd_pkg.sv ====
package axi_rd_pkg;

	localparam int AXI_DATA_W = 32;

	typedef logic [31:0] axi_addr_t;
	typedef logic [7:0] axi_len_t;     // beats - 1
	typedef logic [2:0] axi_size_t;    // log2 of bytes per beat
	typedef logic [1:0] axi_burst_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;

	typedef enum logic [1:0] {
		AXI_RESP_OKAY   = 2'b00,
		AXI_RESP_EXOKAY = 2'b01,
		AXI_RESP_SLVERR = 2'b10,
		AXI_RESP_DECERR = 2'b11
	} axi_resp_t;

	localparam axi_burst_t AXI_BURST_INCR = 2'b01;
	localparam logic [3:0] AXI_CACHE_DEFAULT = 4'b0011; // bufferable, modifiable
	localparam logic [2:0] AXI_PROT_DEFAULT = 3'b000;

	// read address, 45 bits
	typedef struct packed {
		axi_addr_t addr;
		axi_len_t len;
		axi_size_t size;
		axi_burst_t burst;
	} axi_ar_t;

	typedef struct packed {
		axi_data_t data;
		axi_resp_t resp;
		logic last;
	} axi_r_t;

endpackage
